// File: design/mmio_slave_cfg.svh
`ifndef MMIO_SLAVE_CFG_SVH
`define MMIO_SLAVE_CFG_SVH

// Bus widths and register map geometry.
`define MMIO_DATA_WIDTH 16
`define MMIO_ADDR_WIDTH 12
`define MMIO_MEM_SIZE 16

// Byte address of word 0, words step by 4.
`define MMIO_BASE_ADDR 12'h100

// Word indices of the fixed and clamped registers.
`define VERSION_ID 0
`define MEM_SIZE_ID 1
`define MAX_BURST_ID 2
`define BURST_SIZE_ID 3
`define SCALE_ID 4

// Constant contents and clamp limits.
`define FIRMWARE_VERSION 16'h0103
`define MAX_BURST_SIZE 16'd64
`define MAX_SCALE_FACTOR 16'd15

// Reset value of every general register.
`define GENERAL_RESET 16'hffff

`endif

// File: design/mmio_slave_pkg.sv
`default_nettype none

`include "mmio_slave_cfg.svh"

package mmio_slave_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	typedef enum logic [1:0] {
		WR_COLLECT,
		WR_ISSUE,
		WR_RESPOND
	} wr_state_e;

	typedef logic [$clog2(`MMIO_MEM_SIZE)-1:0] reg_id_t;

	// True for a word-aligned byte address inside the map.
	function automatic logic addr_in_map(input logic [`MMIO_ADDR_WIDTH-1:0] addr);
		logic [`MMIO_ADDR_WIDTH-1:0] offset;
		offset = addr - `MMIO_BASE_ADDR;
		return (addr >= `MMIO_BASE_ADDR) && (offset[1:0] == 2'b00) &&
			(offset[`MMIO_ADDR_WIDTH-1:2] < `MMIO_MEM_SIZE);
	endfunction

	function automatic reg_id_t addr_to_id(input logic [`MMIO_ADDR_WIDTH-1:0] addr);
		logic [`MMIO_ADDR_WIDTH-1:0] offset;
		offset = addr - `MMIO_BASE_ADDR;
		return reg_id_t'(offset >> 2);
	endfunction

endpackage

`default_nettype wire

// File: design/reg_access_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

interface reg_access_if;
	import mmio_slave_pkg::*;

	// Write port, one commit per pulse.
	logic wr_req;
	reg_id_t wr_id;
	logic [`MMIO_DATA_WIDTH-1:0] wr_data;

	// Read port, data follows rd_id in the same cycle.
	logic rd_req;
	reg_id_t rd_id;
	logic [`MMIO_DATA_WIDTH-1:0] rd_data;

	modport writer (
		output wr_req, wr_id, wr_data
	);

	modport reader (
		output rd_req, rd_id,
		input rd_data
	);

	modport bank (
		input wr_req, wr_id, wr_data, rd_req, rd_id,
		output rd_data
	);

endinterface

`default_nettype wire

// File: design/write_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module write_channel (
	input logic clk,
	input logic rst_n,
	input logic [`MMIO_ADDR_WIDTH-1:0] wa_addr,
	input logic wa_valid,
	input logic [`MMIO_DATA_WIDTH-1:0] wd_data,
	input logic wd_valid,
	input logic wr_ready,
	output logic wa_ready,
	output logic wd_ready,
	output mmio_slave_pkg::resp_e wr_resp,
	output logic wr_valid,
	reg_access_if.writer acc
);
	import mmio_slave_pkg::*;

	wr_state_e state;
	logic [`MMIO_ADDR_WIDTH-1:0] addr_q;
	logic [`MMIO_DATA_WIDTH-1:0] data_q;
	logic addr_held;
	logic data_held;
	logic wa_fire;
	logic wd_fire;
	logic addr_have;
	logic data_have;
	logic addr_ok;

	assign wa_fire = wa_valid && wa_ready;
	assign wd_fire = wd_valid && wd_ready;

	// Either beat may already be held or arrive on this edge.
	assign addr_have = addr_held || wa_fire;
	assign data_have = data_held || wd_fire;

	assign addr_ok = addr_in_map(addr_q);

	// Out-of-range writes get no pulse and only an error response.
	assign acc.wr_req = (state == WR_ISSUE) && addr_ok;
	assign acc.wr_id = addr_to_id(addr_q);
	assign acc.wr_data = data_q;

	always_ff @(posedge clk) begin
		if (wa_fire)
			addr_q <= wa_addr;
		if (wd_fire)
			data_q <= wd_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WR_COLLECT;
			addr_held <= 1'b0;
			data_held <= 1'b0;
			wa_ready <= 1'b0;
			wd_ready <= 1'b0;
			wr_valid <= 1'b0;
			wr_resp <= OKAY;
		end else begin
			case (state)
				WR_COLLECT: begin
					addr_held <= addr_have;
					data_held <= data_have;
					wa_ready <= !addr_have;
					wd_ready <= !data_have;
					if (addr_have && data_have)
						state <= WR_ISSUE;
				end
				WR_ISSUE: begin
					wr_valid <= 1'b1;
					wr_resp <= addr_ok ? OKAY : SLVERR;
					state <= WR_RESPOND;
				end
				WR_RESPOND: begin
					if (wr_ready) begin
						wr_valid <= 1'b0;
						addr_held <= 1'b0;
						data_held <= 1'b0;
						wa_ready <= 1'b1;
						wd_ready <= 1'b1;
						state <= WR_COLLECT;
					end
				end
				default: state <= WR_COLLECT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/read_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module read_channel (
	input logic clk,
	input logic rst_n,
	input logic [`MMIO_ADDR_WIDTH-1:0] ra_addr,
	input logic ra_valid,
	input logic rd_ready,
	output logic ra_ready,
	output logic [`MMIO_DATA_WIDTH-1:0] rd_data,
	output mmio_slave_pkg::resp_e rd_resp,
	output logic rd_valid,
	reg_access_if.reader acc
);
	import mmio_slave_pkg::*;

	logic ra_fire;
	logic addr_ok;
	logic rd_done;

	assign ra_fire = ra_valid && ra_ready;
	assign rd_done = rd_valid && rd_ready;
	assign addr_ok = addr_in_map(ra_addr);

	// Address is decoded straight from the bus so data lands on the accept edge.
	// The bank returns zero when rd_req is low.
	assign acc.rd_req = ra_fire && addr_ok;
	assign acc.rd_id = addr_to_id(ra_addr);

	always_ff @(posedge clk) begin
		if (ra_fire) begin
			rd_data <= acc.rd_data;
			rd_resp <= addr_ok ? OKAY : SLVERR;
		end
	end

	// One read in flight at a time. The address channel waits for the data beat.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			ra_ready <= 1'b0;
		end else begin
			if (ra_fire) begin
				rd_valid <= 1'b1;
				ra_ready <= 1'b0;
			end else if (rd_done) begin
				rd_valid <= 1'b0;
				ra_ready <= 1'b1;
			end else begin
				ra_ready <= !rd_valid;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module reg_bank (
	input logic clk,
	input logic rst_n,
	input logic [`MMIO_MEM_SIZE-1:0] rtl_write_reqs,
	input logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] rtl_wd_in,
	input logic [`MMIO_MEM_SIZE-1:0] rtl_read_reqs,
	input logic clr_rd_out,
	output logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] rtl_rd_out,
	output logic [`MMIO_MEM_SIZE-1:0] fresh_bits,
	reg_access_if.bank acc
);
	import mmio_slave_pkg::*;

	logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] regs;
	logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] word_next;

	function automatic logic is_read_only(input int idx);
		return (idx == `VERSION_ID) || (idx == `MEM_SIZE_ID) || (idx == `MAX_BURST_ID);
	endfunction

	function automatic logic [`MMIO_DATA_WIDTH-1:0] reset_value(input int idx);
		case (idx)
			`VERSION_ID: return `FIRMWARE_VERSION;
			`MEM_SIZE_ID: return `MMIO_DATA_WIDTH'(`MMIO_MEM_SIZE);
			`MAX_BURST_ID: return `MAX_BURST_SIZE;
			`BURST_SIZE_ID: return '0;
			`SCALE_ID: return '0;
			default: return `GENERAL_RESET;
		endcase
	endfunction

	// Burst size may not exceed the max burst word, scale has its own limit.
	function automatic logic [`MMIO_DATA_WIDTH-1:0] clamp(
		input int idx,
		input logic [`MMIO_DATA_WIDTH-1:0] value
	);
		if ((idx == `BURST_SIZE_ID) && (value > `MAX_BURST_SIZE))
			return `MAX_BURST_SIZE;
		if ((idx == `SCALE_ID) && (value > `MAX_SCALE_FACTOR))
			return `MAX_SCALE_FACTOR;
		return value;
	endfunction

	// Next contents of each word. RTL writes come last so they win a collision.
	always_comb begin
		word_next = regs;
		for (int i = 0; i < `MMIO_MEM_SIZE; i++) begin
			if (acc.wr_req && (acc.wr_id == reg_id_t'(i)))
				word_next[i] = clamp(i, acc.wr_data);
			if (rtl_write_reqs[i])
				word_next[i] = clamp(i, rtl_wd_in[i]);
			if (is_read_only(i))
				word_next[i] = reset_value(i);
		end
	end

	// Reads see writes that commit on the same edge.
	assign acc.rd_data = acc.rd_req ? word_next[acc.rd_id] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MMIO_MEM_SIZE; i++)
				regs[i] <= reset_value(i);
		end else begin
			regs <= word_next;
		end
	end

	// Snapshot words with fresh flags. A strobe beats a clear on the same edge.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rtl_rd_out <= '0;
			fresh_bits <= '0;
		end else begin
			for (int i = 0; i < `MMIO_MEM_SIZE; i++) begin
				if (rtl_read_reqs[i]) begin
					rtl_rd_out[i] <= word_next[i];
					fresh_bits[i] <= 1'b1;
				end else if (clr_rd_out) begin
					rtl_rd_out[i] <= '0;
					fresh_bits[i] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/mmio_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module mmio_slave (
	input logic clk,
	input logic rst_n,
	input logic [`MMIO_ADDR_WIDTH-1:0] wa_addr,
	input logic wa_valid,
	output logic wa_ready,
	input logic [`MMIO_DATA_WIDTH-1:0] wd_data,
	input logic wd_valid,
	output logic wd_ready,
	output logic [1:0] wr_resp,
	output logic wr_valid,
	input logic wr_ready,
	input logic [`MMIO_ADDR_WIDTH-1:0] ra_addr,
	input logic ra_valid,
	output logic ra_ready,
	output logic [`MMIO_DATA_WIDTH-1:0] rd_data,
	output logic [1:0] rd_resp,
	output logic rd_valid,
	input logic rd_ready,
	input logic [`MMIO_MEM_SIZE-1:0] rtl_write_reqs,
	input logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] rtl_wd_in,
	input logic [`MMIO_MEM_SIZE-1:0] rtl_read_reqs,
	input logic clr_rd_out,
	output logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] rtl_rd_out,
	output logic [`MMIO_MEM_SIZE-1:0] fresh_bits
);

	reg_access_if acc ();

	write_channel u_write_channel (
		.clk(clk),
		.rst_n(rst_n),
		.wa_addr(wa_addr),
		.wa_valid(wa_valid),
		.wd_data(wd_data),
		.wd_valid(wd_valid),
		.wr_ready(wr_ready),
		.wa_ready(wa_ready),
		.wd_ready(wd_ready),
		.wr_resp(wr_resp),
		.wr_valid(wr_valid),
		.acc(acc.writer)
	);

	read_channel u_read_channel (
		.clk(clk),
		.rst_n(rst_n),
		.ra_addr(ra_addr),
		.ra_valid(ra_valid),
		.rd_ready(rd_ready),
		.ra_ready(ra_ready),
		.rd_data(rd_data),
		.rd_resp(rd_resp),
		.rd_valid(rd_valid),
		.acc(acc.reader)
	);

	reg_bank u_reg_bank (
		.clk(clk),
		.rst_n(rst_n),
		.rtl_write_reqs(rtl_write_reqs),
		.rtl_wd_in(rtl_wd_in),
		.rtl_read_reqs(rtl_read_reqs),
		.clr_rd_out(clr_rd_out),
		.rtl_rd_out(rtl_rd_out),
		.fresh_bits(fresh_bits),
		.acc(acc.bank)
	);

endmodule

`default_nettype wire

// File: bench/mmio_slave_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module mmio_slave_properties (
	input logic clk,
	input logic rst_n,
	input logic wa_ready,
	input logic wr_valid,
	input logic wr_ready,
	input logic [1:0] wr_resp,
	input logic rd_valid,
	input logic rd_ready,
	input logic [1:0] rd_resp,
	input logic [`MMIO_DATA_WIDTH-1:0] rd_data
);

	// A pending response keeps its payload until the master takes it.
	wr_resp_held: assert property (@(posedge clk) disable iff (!rst_n)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_resp))
		else $error("wr_valid or wr_resp changed before wr_ready");

	rd_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_data) && $stable(rd_resp))
		else $error("rd_valid, rd_data or rd_resp changed before rd_ready");

	// No new address while a response is still pending.
	wa_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		!(wa_ready && wr_valid))
		else $error("wa_ready high while wr_valid is high");

endmodule

bind mmio_slave mmio_slave_properties u_properties (.*);

`default_nettype wire

// File: bench/mmio_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_slave_cfg.svh"

module mmio_slave_tb;
	import mmio_slave_pkg::*;

	typedef enum {OP_WRITE, OP_READ, OP_RTL_WRITE, OP_RTL_READ, OP_CLEAR} op_e;

	typedef struct {
		op_e op;
		logic [`MMIO_ADDR_WIDTH-1:0] addr;
		logic [`MMIO_DATA_WIDTH-1:0] data;
		logic [`MMIO_DATA_WIDTH-1:0] exp_data;
		logic [1:0] exp_resp;
	} step_t;

	logic clk = 1'b0;
	logic rst_n;
	logic [`MMIO_ADDR_WIDTH-1:0] wa_addr, ra_addr;
	logic [`MMIO_DATA_WIDTH-1:0] wd_data, rd_data;
	logic wa_valid, wd_valid, ra_valid, wr_ready, rd_ready, clr_rd_out;
	logic wa_ready, wd_ready, ra_ready, wr_valid, rd_valid;
	logic [1:0] wr_resp, rd_resp;
	logic [`MMIO_MEM_SIZE-1:0] rtl_write_reqs, rtl_read_reqs, fresh_bits;
	logic [`MMIO_MEM_SIZE-1:0][`MMIO_DATA_WIDTH-1:0] rtl_wd_in, rtl_rd_out;

	integer seed = 32'h6aa6_9362;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0;
	int n_steps = 0;
	step_t steps [64];
	logic [`MMIO_DATA_WIDTH-1:0] model [`MMIO_MEM_SIZE];

	mmio_slave i_dut (.*);

	always #5 clk = ~clk;

	// Response back-pressure on both sides.
	initial begin
		logic [31:0] rand_bits;
		wr_ready = 1'b0;
		rd_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rand_bits = $random(seed);
			wr_ready = rand_bits[0];
			rd_ready = rand_bits[1];
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout: the DUT did not finish its handshakes within %0d cycles", limit);
			$display("%0d checks, %0d errors", checks, errors);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [15:0] actual, input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic add_step(input op_e op, input logic [11:0] addr, input logic [15:0] data);
		steps[n_steps].op = op;
		steps[n_steps].addr = addr;
		steps[n_steps].data = data;
		n_steps++;
	endtask

	// Word index of a processor address. Returns -1 outside the map.
	function automatic int map_word(input logic [`MMIO_ADDR_WIDTH-1:0] addr);
		logic [`MMIO_ADDR_WIDTH-1:0] offset;
		offset = addr - `MMIO_BASE_ADDR;
		if (addr < `MMIO_BASE_ADDR || offset[1:0] != 2'b00)
			return -1;
		if (offset >= `MMIO_ADDR_WIDTH'(4 * `MMIO_MEM_SIZE))
			return -1;
		return int'(offset / 4);
	endfunction

	task automatic model_write(input int word, input logic [15:0] value);
		if (word == `VERSION_ID || word == `MEM_SIZE_ID || word == `MAX_BURST_ID)
			return;
		if (word == `BURST_SIZE_ID && value > model[`MAX_BURST_ID])
			value = model[`MAX_BURST_ID];
		if (word == `SCALE_ID && value > `MAX_SCALE_FACTOR)
			value = `MAX_SCALE_FACTOR;
		model[word] = value;
	endtask

	task automatic send_write(input logic [11:0] addr, input logic [15:0] data,
		output logic [1:0] resp);
		int order;
		int gap;
		logic a_done;
		logic d_done;
		order = $unsigned($random(seed)) % 3;
		gap = $unsigned($random(seed)) % 4;
		a_done = 1'b0;
		d_done = 1'b0;
		wa_addr = addr;
		wd_data = data;
		// Order 0 sends the address first, 1 the data first, 2 both together.
		wa_valid = (order != 1);
		wd_valid = (order != 0);
		while (!(a_done && d_done)) begin
			@(negedge clk);
			a_done = a_done || (wa_valid && wa_ready);
			d_done = d_done || (wd_valid && wd_ready);
			@(posedge clk);
			#1;
			wa_valid = wa_valid && !a_done;
			wd_valid = wd_valid && !d_done;
			if (gap > 0 && (a_done || d_done)) begin
				gap--;
			end else if (a_done || d_done) begin
				wa_valid = !a_done;
				wd_valid = !d_done;
			end
		end
		@(negedge clk);
		while (!(wr_valid && wr_ready))
			@(negedge clk);
		resp = wr_resp;
		@(posedge clk);
		#1;
	endtask

	task automatic send_read(input logic [11:0] addr, output logic [15:0] data,
		output logic [1:0] resp);
		ra_addr = addr;
		ra_valid = 1'b1;
		@(negedge clk);
		while (!ra_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		ra_valid = 1'b0;
		@(negedge clk);
		while (!(rd_valid && rd_ready))
			@(negedge clk);
		data = rd_data;
		resp = rd_resp;
		@(posedge clk);
		#1;
	endtask

	initial begin
		logic [15:0] data;
		logic [1:0] resp;
		int word;
		rst_n = 1'b0;
		{wa_addr, ra_addr, wd_data} = '0;
		{wa_valid, wd_valid, ra_valid, clr_rd_out} = '0;
		{rtl_write_reqs, rtl_read_reqs, rtl_wd_in} = '0;

		// Reset contents over both sides.
		add_step(OP_READ, 12'h100, 0);
		add_step(OP_READ, 12'h104, 0);
		add_step(OP_READ, 12'h108, 0);
		add_step(OP_READ, 12'h10c, 0);
		add_step(OP_READ, 12'h110, 0);
		add_step(OP_READ, 12'h13c, 0);
		add_step(OP_RTL_READ, 0, 0);
		add_step(OP_RTL_READ, 1, 0);
		add_step(OP_RTL_READ, 2, 0);
		add_step(OP_RTL_READ, 3, 0);
		add_step(OP_RTL_READ, 4, 0);
		add_step(OP_RTL_READ, 7, 0);
		add_step(OP_CLEAR, 0, 0);
		// Processor writes, clamps and read-only words.
		add_step(OP_WRITE, 12'h118, 16'h1234);
		add_step(OP_READ, 12'h118, 0);
		add_step(OP_WRITE, 12'h10c, 16'd100);
		add_step(OP_READ, 12'h10c, 0);
		add_step(OP_WRITE, 12'h110, 16'd40);
		add_step(OP_READ, 12'h110, 0);
		add_step(OP_WRITE, 12'h100, 16'hdead);
		add_step(OP_READ, 12'h100, 0);
		// Unaligned and out-of-range accesses.
		add_step(OP_READ, 12'h102, 0);
		add_step(OP_READ, 12'h140, 0);
		add_step(OP_WRITE, 12'h0fc, 16'h5555);
		add_step(OP_WRITE, 12'h11a, 16'h7777);
		add_step(OP_READ, 12'h118, 0);
		// RTL side writes and snapshots.
		add_step(OP_RTL_WRITE, 9, 16'hbeef);
		add_step(OP_READ, 12'h124, 0);
		add_step(OP_RTL_WRITE, 3, 16'd200);
		add_step(OP_READ, 12'h10c, 0);
		add_step(OP_RTL_READ, 9, 0);
		add_step(OP_CLEAR, 0, 0);

		for (int w = 0; w < `MMIO_MEM_SIZE; w++)
			model[w] = `GENERAL_RESET;
		model[`VERSION_ID] = `FIRMWARE_VERSION;
		model[`MEM_SIZE_ID] = `MMIO_MEM_SIZE;
		model[`MAX_BURST_ID] = `MAX_BURST_SIZE;
		model[`BURST_SIZE_ID] = '0;
		model[`SCALE_ID] = '0;
		for (int i = 0; i < n_steps; i++) begin
			word = (steps[i].op inside {OP_WRITE, OP_READ}) ?
				map_word(steps[i].addr) : int'(steps[i].addr);
			steps[i].exp_resp = (word < 0) ? SLVERR : OKAY;
			steps[i].exp_data = '0;
			if (word >= 0 && steps[i].op inside {OP_READ, OP_RTL_READ})
				steps[i].exp_data = model[word];
			if (word >= 0 && steps[i].op inside {OP_WRITE, OP_RTL_WRITE})
				model_write(word, steps[i].data);
		end
		limit = n_steps * 40;

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < n_steps; i++) begin
			word = int'(steps[i].addr[3:0]);
			case (steps[i].op)
				OP_WRITE: begin
					send_write(steps[i].addr, steps[i].data, resp);
					check("wr_resp", 16'(resp), 16'(steps[i].exp_resp));
				end
				OP_READ: begin
					send_read(steps[i].addr, data, resp);
					check("rd_data", data, steps[i].exp_data);
					check("rd_resp", 16'(resp), 16'(steps[i].exp_resp));
				end
				OP_RTL_WRITE: begin
					rtl_write_reqs[word] = 1'b1;
					rtl_wd_in[word] = steps[i].data;
					@(posedge clk);
					#1;
					rtl_write_reqs = '0;
				end
				OP_RTL_READ: begin
					rtl_read_reqs[word] = 1'b1;
					@(posedge clk);
					#1;
					rtl_read_reqs = '0;
					check("rtl_rd_out", rtl_rd_out[word], steps[i].exp_data);
					check("fresh_bits", 16'(fresh_bits[word]), 16'd1);
				end
				default: begin
					clr_rd_out = 1'b1;
					@(posedge clk);
					#1;
					clr_rd_out = 1'b0;
					check("fresh_bits", fresh_bits, 16'd0);
					for (int w = 0; w < `MMIO_MEM_SIZE; w++)
						check("rtl_rd_out", rtl_rd_out[w], 16'd0);
				end
			endcase
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: mmio_slave.f
+incdir+design
design/mmio_slave_pkg.sv
design/reg_access_if.sv
design/write_channel.sv
design/read_channel.sv
design/reg_bank.sv
design/mmio_slave.sv
bench/mmio_slave_properties.sv
bench/mmio_slave_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmio_slave_tb \
	-f mmio_slave.f -o mmio_slave_sim

sim_output="$(./obj_dir/mmio_slave_sim)" || true
echo "$sim_output"

if grep -qx "TESTS PASSED" <<< "$sim_output"; then
	exit 0
fi
exit 1
